// File: Makefile
# Verilator build and run for the recovery subsystem

TOOL       ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_recovery_subsystem
FILELIST   := recovery_subsystem.f

OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit status
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/fault_monitor.sv
// Fault monitor with heartbeat watchdog, fault request intake, trigger and recovery stats
module fault_monitor import rec_pkg::*; #(
    parameter int HB_TIMEOUT = 200
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   heartbeat,
    input  logic                   fault_req,
    input  logic                   recovery_in_progress,
    output logic                   trigger_recovery,
    output logic [REC_COUNT_W-1:0] recovery_count,
    output rec_cause_t             last_cause
);

    // Watchdog counter must hold values up to HB_TIMEOUT-1
    localparam int WD_W = (HB_TIMEOUT > 1) ? $clog2(HB_TIMEOUT) : 1;
    localparam logic [WD_W-1:0] WD_LAST = WD_W'(HB_TIMEOUT - 1);

    logic [WD_W-1:0] wd_cnt;
    logic            blocked;
    logic            wd_fire;
    logic            ext_fire;
    logic            any_fire;

    // ====================
    // Event filtering
    // ====================

    // No new events while a recovery runs
    // The trigger cycle itself is also blocked, since in_progress only rises after it
    assign blocked  = recovery_in_progress | trigger_recovery;

    // Timeout when the last counted cycle passes with no heartbeat
    assign wd_fire  = !blocked && !heartbeat && (wd_cnt == WD_LAST);
    assign ext_fire = !blocked && fault_req;
    assign any_fire = wd_fire | ext_fire;

    // ====================
    // Heartbeat watchdog
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wd_cnt <= '0;
        end else if (heartbeat || blocked || wd_fire) begin
            // Restart on heartbeat, hold at zero through a recovery
            wd_cnt <= '0;
        end else begin
            wd_cnt <= wd_cnt + 1'b1;
        end
    end

    // ====================
    // Trigger and stats
    // ====================

    // Registered trigger, one cycle wide because the next cycle is blocked
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trigger_recovery <= 1'b0;
        end else begin
            trigger_recovery <= any_fire;
        end
    end

    // Count and cause move on the same edge that raises the trigger
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recovery_count <= '0;
            last_cause     <= CAUSE_NONE;
        end else if (any_fire) begin
            // Saturate at all ones
            if (recovery_count != {REC_COUNT_W{1'b1}}) begin
                recovery_count <= recovery_count + 1'b1;
            end
            if (wd_fire && ext_fire) begin
                last_cause <= CAUSE_BOTH;
            end else if (wd_fire) begin
                last_cause <= CAUSE_WATCHDOG;
            end else begin
                last_cause <= CAUSE_EXTERNAL;
            end
        end
    end

    // Trigger is a single-cycle pulse
    a_trigger_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        trigger_recovery |=> !trigger_recovery
    );

endmodule

// File: hdl/rec_pkg.sv
// Recovery stage codes, recovery cause codes and recovery counter width
package rec_pkg;

    // ====================
    // Recovery stages
    // ====================

    // Stage code seen on recovery_stage, idle between recoveries
    typedef enum logic [3:0] {
        STG_IDLE      = 4'd0,
        STG_SYS_RESET = 4'd1,
        STG_MOD_RESET = 4'd2,
        STG_MEM_CLEAR = 4'd3,
        STG_SETTLE    = 4'd4
    } rec_stage_t;

    // ====================
    // Recovery causes
    // ====================

    // Both bits set when watchdog and external request hit in one cycle
    typedef enum logic [1:0] {
        CAUSE_NONE     = 2'd0,
        CAUSE_WATCHDOG = 2'd1,
        CAUSE_EXTERNAL = 2'd2,
        CAUSE_BOTH     = 2'd3
    } rec_cause_t;

    // Saturating recovery counter width
    localparam int REC_COUNT_W = 8;

endpackage

// File: hdl/recovery_sequencer.sv
// Recovery sequencer FSM with stage timing, stage code and reset/clear levels
module recovery_sequencer import rec_pkg::*; #(
    parameter int SYS_RST_CYCLES = 32,
    parameter int MOD_RST_CYCLES = 16,
    parameter int MEM_CLR_CYCLES = 64,
    parameter int SETTLE_CYCLES  = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       trigger_recovery,
    output rec_stage_t recovery_stage,
    output logic       recovery_in_progress,
    output logic       system_reset,
    output logic       module_reset,
    output logic       memory_clear
);

    // Longest stage sets the cycle counter width
    localparam int MAX_AB  = (SYS_RST_CYCLES > MOD_RST_CYCLES) ? SYS_RST_CYCLES : MOD_RST_CYCLES;
    localparam int MAX_CD  = (MEM_CLR_CYCLES > SETTLE_CYCLES) ? MEM_CLR_CYCLES : SETTLE_CYCLES;
    localparam int MAX_LEN = (MAX_AB > MAX_CD) ? MAX_AB : MAX_CD;
    localparam int CNT_W   = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1;

    // Last counter value of each stage
    localparam logic [CNT_W-1:0] SYS_LAST = CNT_W'(SYS_RST_CYCLES - 1);
    localparam logic [CNT_W-1:0] MOD_LAST = CNT_W'(MOD_RST_CYCLES - 1);
    localparam logic [CNT_W-1:0] CLR_LAST = CNT_W'(MEM_CLR_CYCLES - 1);
    localparam logic [CNT_W-1:0] SET_LAST = CNT_W'(SETTLE_CYCLES - 1);

    rec_stage_t       state;
    rec_stage_t       next_state;
    rec_stage_t       stage_follow;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] next_cnt;
    logic [CNT_W-1:0] stage_last;

    // ====================
    // Stage table
    // ====================

    // Length and successor of the current stage
    always_comb begin
        stage_last   = '0;
        stage_follow = STG_IDLE;
        case (state)
            STG_SYS_RESET: begin
                stage_last   = SYS_LAST;
                stage_follow = STG_MOD_RESET;
            end
            STG_MOD_RESET: begin
                stage_last   = MOD_LAST;
                stage_follow = STG_MEM_CLEAR;
            end
            STG_MEM_CLEAR: begin
                stage_last   = CLR_LAST;
                stage_follow = STG_SETTLE;
            end
            // Settle returns to idle via the default successor
            STG_SETTLE: stage_last = SET_LAST;
            default: begin
                stage_last   = '0;
                stage_follow = STG_IDLE;
            end
        endcase
    end

    // ====================
    // Next state
    // ====================

    always_comb begin
        next_state = state;
        next_cnt   = cnt;
        if (state == STG_IDLE) begin
            if (trigger_recovery) begin
                next_state = STG_SYS_RESET;
                next_cnt   = '0;
            end
        end else if ((state != STG_SYS_RESET) && (state != STG_MOD_RESET) &&
                     (state != STG_MEM_CLEAR) && (state != STG_SETTLE)) begin
            // Unused code, fall back to idle
            next_state = STG_IDLE;
            next_cnt   = '0;
        end else if (cnt == stage_last) begin
            next_state = stage_follow;
            next_cnt   = '0;
        end else begin
            next_cnt = cnt + 1'b1;
        end
    end

    // State and per-stage cycle counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= STG_IDLE;
            cnt   <= '0;
        end else begin
            state <= next_state;
            cnt   <= next_cnt;
        end
    end

    assign recovery_stage = state;

    // ====================
    // Output levels
    // ====================

    // Decoded from next_state so the levels switch on the same edge as the stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recovery_in_progress <= 1'b0;
            system_reset         <= 1'b0;
            module_reset         <= 1'b0;
            memory_clear         <= 1'b0;
        end else begin
            recovery_in_progress <= (next_state != STG_IDLE);
            system_reset         <= (next_state == STG_SYS_RESET);
            module_reset         <= (next_state == STG_MOD_RESET);
            memory_clear         <= (next_state == STG_MEM_CLEAR);
        end
    end

    // Never two actions at once
    a_one_action: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({system_reset, module_reset, memory_clear})
    );

    // Busy flag tracks the stage register
    a_busy_stage: assert property (
        @(posedge clk) disable iff (!rst_n)
        recovery_in_progress == (recovery_stage != STG_IDLE)
    );

endmodule

// File: hdl/recovery_subsystem.sv
// Fault recovery subsystem top with monitor, sequencer and scratch RAM
module recovery_subsystem import rec_pkg::*; #(
    parameter int HB_TIMEOUT     = 200,
    parameter int SYS_RST_CYCLES = 32,
    parameter int MOD_RST_CYCLES = 16,
    parameter int MEM_CLR_CYCLES = 64,
    parameter int SETTLE_CYCLES  = 32,
    parameter int RAM_DEPTH      = 64,
    parameter int RAM_WIDTH      = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // Host events
    input  logic                   heartbeat,
    input  logic                   fault_req,
    // Host RAM access
    input  logic                   ram_wr_en,
    input  logic [$clog2(RAM_DEPTH > 1 ? RAM_DEPTH : 2)-1:0] ram_addr,
    input  logic [RAM_WIDTH-1:0]   ram_wr_data,
    output logic [RAM_WIDTH-1:0]   ram_rd_data,
    // Sequencer status
    output rec_stage_t             recovery_stage,
    output logic                   recovery_in_progress,
    output logic                   system_reset,
    output logic                   module_reset,
    output logic                   memory_clear,
    // Monitor stats
    output logic [REC_COUNT_W-1:0] recovery_count,
    output rec_cause_t             last_cause
);

    // Pulse from monitor into sequencer
    logic trigger_recovery;

    // ====================
    // Fault detection
    // ====================

    fault_monitor #(
        .HB_TIMEOUT (HB_TIMEOUT)
    ) u_monitor (
        .clk                  (clk),
        .rst_n                (rst_n),
        .heartbeat            (heartbeat),
        .fault_req            (fault_req),
        .recovery_in_progress (recovery_in_progress),
        .trigger_recovery     (trigger_recovery),
        .recovery_count       (recovery_count),
        .last_cause           (last_cause)
    );

    // ====================
    // Recovery sequence
    // ====================

    recovery_sequencer #(
        .SYS_RST_CYCLES (SYS_RST_CYCLES),
        .MOD_RST_CYCLES (MOD_RST_CYCLES),
        .MEM_CLR_CYCLES (MEM_CLR_CYCLES),
        .SETTLE_CYCLES  (SETTLE_CYCLES)
    ) u_sequencer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .trigger_recovery     (trigger_recovery),
        .recovery_stage       (recovery_stage),
        .recovery_in_progress (recovery_in_progress),
        .system_reset         (system_reset),
        .module_reset         (module_reset),
        .memory_clear         (memory_clear)
    );

    // ====================
    // Scratch memory
    // ====================

    // Cleared by the memory-clear stage
    scratch_ram #(
        .RAM_DEPTH (RAM_DEPTH),
        .RAM_WIDTH (RAM_WIDTH)
    ) u_ram (
        .clk          (clk),
        .rst_n        (rst_n),
        .memory_clear (memory_clear),
        .ram_wr_en    (ram_wr_en),
        .ram_addr     (ram_addr),
        .ram_wr_data  (ram_wr_data),
        .ram_rd_data  (ram_rd_data)
    );

endmodule

// File: hdl/scratch_ram.sv
// Scratch RAM with synchronous read, host write port and zero-sweep clear engine
module scratch_ram #(
    parameter int RAM_DEPTH = 64,
    parameter int RAM_WIDTH = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              memory_clear,
    input  logic                              ram_wr_en,
    input  logic [$clog2(RAM_DEPTH > 1 ? RAM_DEPTH : 2)-1:0] ram_addr,
    input  logic [RAM_WIDTH-1:0]              ram_wr_data,
    output logic [RAM_WIDTH-1:0]              ram_rd_data
);

    localparam int ADDR_W = $clog2(RAM_DEPTH > 1 ? RAM_DEPTH : 2);

    // One extra bit so the sweep count can reach RAM_DEPTH
    localparam logic [ADDR_W:0] SWEEP_END  = (ADDR_W + 1)'(RAM_DEPTH);
    localparam logic [ADDR_W:0] SWEEP_LAST = (ADDR_W + 1)'(RAM_DEPTH - 1);

    logic [RAM_WIDTH-1:0] mem [RAM_DEPTH];
    logic [ADDR_W:0]      sweep_cnt;
    logic                 sweep_active;

    // ====================
    // Clear engine
    // ====================

    // Writing zeros until every word is covered
    assign sweep_active = memory_clear && (sweep_cnt < SWEEP_END);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_cnt <= '0;
        end else if (!memory_clear) begin
            // Rearm for the next clear request
            sweep_cnt <= '0;
        end else if (sweep_active) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    // ====================
    // Storage
    // ====================

    // Sweep wins, host writes dropped for the whole clear request
    always_ff @(posedge clk) begin
        if (sweep_active) begin
            mem[sweep_cnt[ADDR_W-1:0]] <= '0;
        end else if (ram_wr_en && !memory_clear) begin
            mem[ram_addr] <= ram_wr_data;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        ram_rd_data <= mem[ram_addr];
    end

    // Clear must stay up until the last word has been zeroed
    a_sweep_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        (memory_clear && (sweep_cnt < SWEEP_LAST)) |=> memory_clear
    );

endmodule

// File: recovery_subsystem.f
hdl/rec_pkg.sv
hdl/fault_monitor.sv
hdl/recovery_sequencer.sv
hdl/scratch_ram.sv
hdl/recovery_subsystem.sv
tests/tb_recovery_subsystem.sv

// File: tests/tb_recovery_subsystem.sv
// Recovery subsystem testbench with stage reference model, sequence checker, compare tasks and watchdog
module tb_recovery_subsystem import rec_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 4;
    localparam int HB_TIMEOUT     = 200;
    localparam int SYS_RST_CYCLES = 32;
    localparam int MOD_RST_CYCLES = 16;
    localparam int MEM_CLR_CYCLES = 64;
    localparam int SETTLE_CYCLES  = 32;
    localparam int RAM_DEPTH      = 64;
    localparam int RAM_WIDTH      = 16;
    localparam int ADDR_W         = $clog2(RAM_DEPTH);
    // One full recovery in cycles
    localparam int SEQ_LEN = SYS_RST_CYCLES + MOD_RST_CYCLES + MEM_CLR_CYCLES + SETTLE_CYCLES;
    // Heartbeats well inside the watchdog limit
    localparam int HB_PERIOD = HB_TIMEOUT / 4;
    localparam int COUNT_MAX = (1 << REC_COUNT_W) - 1;
    // Back-to-back recoveries, enough to pass saturation
    localparam int SAT_RUNS        = COUNT_MAX + 1;
    localparam int N_RECOVERIES    = 5 + SAT_RUNS;
    localparam int WATCHDOG_CYCLES = N_RECOVERIES * (SEQ_LEN + HB_TIMEOUT) + 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   heartbeat;
    logic                   fault_req;
    logic                   ram_wr_en;
    logic [ADDR_W-1:0]      ram_addr;
    logic [RAM_WIDTH-1:0]   ram_wr_data;
    logic [RAM_WIDTH-1:0]   ram_rd_data;
    rec_stage_t             recovery_stage;
    logic                   recovery_in_progress;
    logic                   system_reset;
    logic                   module_reset;
    logic                   memory_clear;
    logic [REC_COUNT_W-1:0] recovery_count;
    rec_cause_t             last_cause;

    integer               seed = 70;
    bit                   hb_enable;
    int                   cyc;
    int                   exp_count;
    // Host view of the RAM contents
    logic [RAM_WIDTH-1:0] shadow [RAM_DEPTH];
    bit                   written [RAM_DEPTH];

    recovery_subsystem #(
        .HB_TIMEOUT     (HB_TIMEOUT),
        .SYS_RST_CYCLES (SYS_RST_CYCLES),
        .MOD_RST_CYCLES (MOD_RST_CYCLES),
        .MEM_CLR_CYCLES (MEM_CLR_CYCLES),
        .SETTLE_CYCLES  (SETTLE_CYCLES),
        .RAM_DEPTH      (RAM_DEPTH),
        .RAM_WIDTH      (RAM_WIDTH)
    ) uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .heartbeat            (heartbeat),
        .fault_req            (fault_req),
        .ram_wr_en            (ram_wr_en),
        .ram_addr             (ram_addr),
        .ram_wr_data          (ram_wr_data),
        .ram_rd_data          (ram_rd_data),
        .recovery_stage       (recovery_stage),
        .recovery_in_progress (recovery_in_progress),
        .system_reset         (system_reset),
        .module_reset         (module_reset),
        .memory_clear         (memory_clear),
        .recovery_count       (recovery_count),
        .last_cause           (last_cause)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================

    // Stage expected a given number of cycles after the trigger cycle
    function automatic rec_stage_t expected_stage(int elapsed, int sys_len, int mod_len,
                                                  int clr_len, int set_len);
        if (elapsed < 1) return STG_IDLE;
        if (elapsed <= sys_len) return STG_SYS_RESET;
        if (elapsed <= sys_len + mod_len) return STG_MOD_RESET;
        if (elapsed <= sys_len + mod_len + clr_len) return STG_MEM_CLEAR;
        if (elapsed <= sys_len + mod_len + clr_len + set_len) return STG_SETTLE;
        return STG_IDLE;
    endfunction

    // ====================
    // Compare tasks
    // ====================

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        fail_run($sformatf("mismatch %s expected 0x%0h actual 0x%0h", name, exp, act));
    endtask

    task automatic check_stage(rec_stage_t exp, rec_stage_t act);
        if (act !== exp) report_mismatch("recovery_stage", 32'(exp), 32'(act));
    endtask

    task automatic check_level(string name, logic exp, logic act);
        if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_count(logic [REC_COUNT_W-1:0] exp, logic [REC_COUNT_W-1:0] act);
        if (act !== exp) report_mismatch("recovery_count", 32'(exp), 32'(act));
    endtask

    task automatic check_cause(rec_cause_t exp, rec_cause_t act);
        if (act !== exp) report_mismatch("last_cause", 32'(exp), 32'(act));
    endtask

    task automatic check_data(int addr, logic [RAM_WIDTH-1:0] exp, logic [RAM_WIDTH-1:0] act);
        if (act !== exp) report_mismatch($sformatf("ram_rd_data[%0d]", addr), 32'(exp), 32'(act));
    endtask

    // ====================
    // Stimulus helpers
    // ====================

    // One clock on the falling edge, heartbeat generated here
    task automatic tick();
        @(negedge clk);
        cyc = cyc + 1;
        heartbeat = hb_enable && ((cyc % HB_PERIOD) == 0);
    endtask

    task automatic pulse_fault();
        fault_req = 1'b1;
        tick();
        fault_req = 1'b0;
    endtask

    task automatic wait_start(int limit, string what);
        int n;
        n = 0;
        while (!recovery_in_progress) begin
            if (n >= limit) fail_run(what);
            tick();
            n = n + 1;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (recovery_in_progress) begin
            if (n >= SEQ_LEN + 4) fail_run("recovery did not return to idle in time");
            tick();
            n = n + 1;
        end
    endtask

    task automatic wait_clear();
        int n;
        n = 0;
        while (!memory_clear) begin
            if (n >= SEQ_LEN) fail_run("memory_clear never rose during the recovery");
            tick();
            n = n + 1;
        end
    endtask

    task automatic write_word(logic [ADDR_W-1:0] addr, logic [RAM_WIDTH-1:0] data);
        ram_wr_en   = 1'b1;
        ram_addr    = addr;
        ram_wr_data = data;
        tick();
        ram_wr_en   = 1'b0;
    endtask

    // Synchronous read, data is valid one clock after the address
    task automatic read_check(logic [ADDR_W-1:0] addr, logic [RAM_WIDTH-1:0] exp);
        ram_addr = addr;
        tick();
        check_data(int'(addr), exp, ram_rd_data);
    endtask

    // Saturating model of the recovery counter
    task automatic bump_count();
        if (exp_count < COUNT_MAX) exp_count = exp_count + 1;
    endtask

    // ====================
    // Sequence checker
    // ====================

    // Aligns on the rise of recovery_in_progress, trigger cycle is one before
    initial begin
        int         elapsed;
        logic       prev_busy;
        rec_stage_t exp_stg;
        elapsed   = 0;
        prev_busy = 1'b0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (recovery_in_progress && !prev_busy) begin
                elapsed = 1;
            end else if (elapsed > 0 && elapsed <= SEQ_LEN) begin
                elapsed = elapsed + 1;
            end else begin
                elapsed = 0;
            end
            exp_stg = expected_stage(elapsed, SYS_RST_CYCLES, MOD_RST_CYCLES,
                                     MEM_CLR_CYCLES, SETTLE_CYCLES);
            check_stage(exp_stg, recovery_stage);
            check_level("recovery_in_progress", exp_stg != STG_IDLE, recovery_in_progress);
            check_level("system_reset", exp_stg == STG_SYS_RESET, system_reset);
            check_level("module_reset", exp_stg == STG_MOD_RESET, module_reset);
            check_level("memory_clear", exp_stg == STG_MEM_CLEAR, memory_clear);
            prev_busy = recovery_in_progress;
        end
    end

    // Hang guard sized from the number of recoveries
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    // ====================
    // Main sequence
    // ====================

    initial begin
        logic [ADDR_W-1:0]    addr;
        logic [RAM_WIDTH-1:0] data;
        int                   i;
        rst_n       = 1'b0;
        heartbeat   = 1'b0;
        fault_req   = 1'b0;
        ram_wr_en   = 1'b0;
        ram_addr    = '0;
        ram_wr_data = '0;
        hb_enable   = 1'b0;
        cyc         = 0;
        exp_count   = 0;
        for (i = 0; i < RAM_DEPTH; i++) written[i] = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        tick();

        // Quiet state out of reset
        check_stage(STG_IDLE, recovery_stage);
        check_level("system_reset", 1'b0, system_reset);
        check_count('0, recovery_count);
        check_cause(CAUSE_NONE, last_cause);

        // Regular heartbeats keep the watchdog quiet
        hb_enable = 1'b1;
        repeat (3 * HB_TIMEOUT) begin
            tick();
            if (recovery_in_progress) fail_run("recovery started although heartbeats were regular");
        end
        pulse_fault();
        wait_start(4, "no recovery after fault_req");
        wait_idle();
        bump_count();
        check_count(REC_COUNT_W'(exp_count), recovery_count);
        check_cause(CAUSE_EXTERNAL, last_cause);

        // Heartbeats stop, watchdog must fire
        hb_enable = 1'b0;
        wait_start(HB_TIMEOUT + 8, "watchdog recovery did not start in time");
        wait_idle();
        bump_count();
        check_count(REC_COUNT_W'(exp_count), recovery_count);
        check_cause(CAUSE_WATCHDOG, last_cause);
        hb_enable = 1'b1;

        // Random writes then readback
        for (i = 0; i < 40; i++) begin
            addr = ADDR_W'($random(seed));
            data = RAM_WIDTH'($random(seed));
            write_word(addr, data);
            shadow[addr]  = data;
            written[addr] = 1'b1;
        end
        for (i = 0; i < RAM_DEPTH; i++) begin
            if (written[i]) read_check(ADDR_W'(i), shadow[i]);
        end

        // Recovery wipes the RAM, host write during clear is dropped
        pulse_fault();
        wait_start(4, "no recovery after fault_req");
        wait_clear();
        repeat (10) tick();
        write_word('0, RAM_WIDTH'($random(seed)) | RAM_WIDTH'(1));
        wait_idle();
        bump_count();
        check_count(REC_COUNT_W'(exp_count), recovery_count);
        check_cause(CAUSE_EXTERNAL, last_cause);
        for (i = 0; i < RAM_DEPTH; i++) read_check(ADDR_W'(i), '0);

        // Fault requests inside a recovery are dropped
        pulse_fault();
        wait_start(4, "no recovery after fault_req");
        repeat (6) begin
            repeat (20) tick();
            pulse_fault();
        end
        wait_idle();
        bump_count();
        repeat (10) begin
            tick();
            if (recovery_in_progress) fail_run("fault_req during a recovery started another one");
        end
        check_count(REC_COUNT_W'(exp_count), recovery_count);

        // Held request gives back-to-back recoveries up to saturation
        fault_req = 1'b1;
        for (i = 0; i < SAT_RUNS; i++) begin
            wait_start(4, "back-to-back recovery did not start");
            wait_idle();
            bump_count();
            check_count(REC_COUNT_W'(exp_count), recovery_count);
            check_cause(CAUSE_EXTERNAL, last_cause);
        end
        fault_req = 1'b0;
        repeat (10) tick();
        check_count(REC_COUNT_W'(COUNT_MAX), recovery_count);

        $display("Simulation passed");
        $finish;
    end

endmodule
